//--- hdl/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// datapath widths
`define ID_XLEN         32
`define ID_REG_ADDR_W   5
`define ID_IMM_W        32

// RV32I major opcodes
`define ID_OPC_LOAD     7'b0000011
`define ID_OPC_STORE    7'b0100011
`define ID_OPC_BRANCH   7'b1100011
`define ID_OPC_JALR     7'b1100111
`define ID_OPC_JAL      7'b1101111
`define ID_OPC_OP_IMM   7'b0010011
`define ID_OPC_OP       7'b0110011
`define ID_OPC_AUIPC    7'b0010111
`define ID_OPC_LUI      7'b0110111

// alu operations, zero is no operation
`define ID_ALU_ADD      4'd1
`define ID_ALU_SUB      4'd2
`define ID_ALU_XOR      4'd3
`define ID_ALU_OR       4'd4
`define ID_ALU_AND      4'd5
`define ID_ALU_SRL      4'd6
`define ID_ALU_SRA      4'd7
`define ID_ALU_SLL      4'd8
`define ID_ALU_SLT      4'd9
`define ID_ALU_SLTU     4'd10

// alu operand selects
`define ID_SRC1_ZERO    2'd0
`define ID_SRC1_REG1    2'd1
`define ID_SRC1_PC      2'd2
`define ID_SRC2_ZERO    2'd0
`define ID_SRC2_REG2    2'd1
`define ID_SRC2_IMM     2'd2
`define ID_SRC2_FOUR    2'd3

// memory access types, zero is no access
`define ID_LOAD_LB      3'd1
`define ID_LOAD_LBU     3'd2
`define ID_LOAD_LH      3'd3
`define ID_LOAD_LHU     3'd4
`define ID_LOAD_LW      3'd5
`define ID_STORE_SB     2'd1
`define ID_STORE_SH     2'd2
`define ID_STORE_SW     2'd3

// branch conditions
`define ID_BR_NONE      3'd0
`define ID_BR_EQ        3'd1
`define ID_BR_NE        3'd2
`define ID_BR_LT        3'd3
`define ID_BR_GE        3'd4
`define ID_BR_LTU       3'd5
`define ID_BR_GEU       3'd6

`endif

//--- hdl/id_pkg.sv
`default_nettype none

`include "id_params.svh"

package id_pkg;

    // meaningful widths
    typedef logic [`ID_XLEN-1:0]       word_t;
    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]                alu_op_t;
    typedef logic [1:0]                alu_src1_t;
    typedef logic [1:0]                alu_src2_t;
    typedef logic [2:0]                load_type_t;
    typedef logic [1:0]                store_type_t;
    typedef logic [2:0]                branch_cond_t;

    // everything the later stages need from one instruction
    typedef struct packed {
        alu_op_t      alu_op;
        alu_src1_t    src1_sel;
        alu_src2_t    src2_sel;
        word_t        imm;
        reg_addr_t    rd;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        // operand reads that take part in forwarding
        logic         rs1_ren;
        logic         rs2_ren;
        logic         reg_wen;
        load_type_t   load_type;
        store_type_t  store_type;
        branch_cond_t branch_cond;
        // jal or jalr
        logic         jmp;
        // jalr only, target base is rs1
        logic         jalr;
    } decode_t;

    // one forwarding source from a later stage
    typedef struct packed {
        logic      enable;
        reg_addr_t dst;
        word_t     data;
        // result still in flight, consumer must wait
        logic      need_stall;
    } fwd_src_t;

endpackage

`default_nettype wire

//--- hdl/id_decoder.sv
`default_nettype none

`include "id_params.svh"

module id_decoder (
    input  id_pkg::word_t   inst_i,
    output id_pkg::decode_t dec_o
);

    // instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // major opcode classes
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jalr;
    logic is_jal;
    logic is_op_imm;
    logic is_op;
    logic is_auipc;
    logic is_lui;

    assign is_load   = (opcode == `ID_OPC_LOAD);
    assign is_store  = (opcode == `ID_OPC_STORE);
    assign is_branch = (opcode == `ID_OPC_BRANCH);
    assign is_jalr   = (opcode == `ID_OPC_JALR);
    assign is_jal    = (opcode == `ID_OPC_JAL);
    assign is_op_imm = (opcode == `ID_OPC_OP_IMM);
    assign is_op     = (opcode == `ID_OPC_OP);
    assign is_auipc  = (opcode == `ID_OPC_AUIPC);
    assign is_lui    = (opcode == `ID_OPC_LUI);

    // R-type funct7 variants
    logic f7_base;
    logic f7_alt;

    assign f7_base = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // op-imm, shifts need bit 25 clear on RV32
    logic op_addi;
    logic op_slti;
    logic op_sltiu;
    logic op_xori;
    logic op_ori;
    logic op_andi;
    logic op_slli;
    logic op_srli;
    logic op_srai;

    assign op_addi  = is_op_imm & (funct3 == 3'b000);
    assign op_slti  = is_op_imm & (funct3 == 3'b010);
    assign op_sltiu = is_op_imm & (funct3 == 3'b011);
    assign op_xori  = is_op_imm & (funct3 == 3'b100);
    assign op_ori   = is_op_imm & (funct3 == 3'b110);
    assign op_andi  = is_op_imm & (funct3 == 3'b111);
    assign op_slli  = is_op_imm & (funct3 == 3'b001) & (inst_i[31:26] == 6'b000000) & ~inst_i[25];
    assign op_srli  = is_op_imm & (funct3 == 3'b101) & (inst_i[31:26] == 6'b000000) & ~inst_i[25];
    assign op_srai  = is_op_imm & (funct3 == 3'b101) & (inst_i[31:26] == 6'b010000) & ~inst_i[25];

    // register-register
    logic op_add;
    logic op_sub;
    logic op_sll;
    logic op_slt;
    logic op_sltu;
    logic op_xor;
    logic op_srl;
    logic op_sra;
    logic op_or;
    logic op_and;

    assign op_add  = is_op & (funct3 == 3'b000) & f7_base;
    assign op_sub  = is_op & (funct3 == 3'b000) & f7_alt;
    assign op_sll  = is_op & (funct3 == 3'b001) & f7_base;
    assign op_slt  = is_op & (funct3 == 3'b010) & f7_base;
    assign op_sltu = is_op & (funct3 == 3'b011) & f7_base;
    assign op_xor  = is_op & (funct3 == 3'b100) & f7_base;
    assign op_srl  = is_op & (funct3 == 3'b101) & f7_base;
    assign op_sra  = is_op & (funct3 == 3'b101) & f7_alt;
    assign op_or   = is_op & (funct3 == 3'b110) & f7_base;
    assign op_and  = is_op & (funct3 == 3'b111) & f7_base;

    logic op_jalr;

    assign op_jalr = is_jalr & (funct3 == 3'b000);

    // format immediates
    logic [`ID_IMM_W-1:0] imm_i;
    logic [`ID_IMM_W-1:0] imm_s;
    logic [`ID_IMM_W-1:0] imm_b;
    logic [`ID_IMM_W-1:0] imm_u;
    logic [`ID_IMM_W-1:0] imm_j;

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // operand source classes
    logic sel1_reg1;
    logic sel1_pc;
    logic sel2_reg2;
    logic sel2_imm;
    logic sel2_four;

    assign sel1_reg1 = is_op | is_op_imm | is_store | is_load;
    assign sel1_pc   = is_jal | is_jalr | is_auipc;
    assign sel2_reg2 = is_op;
    assign sel2_imm  = is_op_imm | is_lui | is_auipc | is_load | is_store;
    assign sel2_four = is_jal | is_jalr;

    always_comb begin
        dec_o.imm = ({32{is_op_imm | is_jalr | is_load}} & imm_i)
                  | ({32{is_store}}            & imm_s)
                  | ({32{is_branch}}           & imm_b)
                  | ({32{is_lui | is_auipc}}   & imm_u)
                  | ({32{is_jal}}              & imm_j);

        // address and link arithmetic all go through the adder
        dec_o.alu_op = ({4{op_add | op_addi | op_jalr | is_store | is_load | is_jal
                           | is_auipc | is_lui}} & `ID_ALU_ADD)
                     | ({4{op_sub}}             & `ID_ALU_SUB)
                     | ({4{op_xor | op_xori}}   & `ID_ALU_XOR)
                     | ({4{op_or | op_ori}}     & `ID_ALU_OR)
                     | ({4{op_and | op_andi}}   & `ID_ALU_AND)
                     | ({4{op_srl | op_srli}}   & `ID_ALU_SRL)
                     | ({4{op_sra | op_srai}}   & `ID_ALU_SRA)
                     | ({4{op_sll | op_slli}}   & `ID_ALU_SLL)
                     | ({4{op_slt | op_slti}}   & `ID_ALU_SLT)
                     | ({4{op_sltu | op_sltiu}} & `ID_ALU_SLTU);

        // lui and unknown opcodes fall to zero
        if (sel1_reg1) begin
            dec_o.src1_sel = `ID_SRC1_REG1;
        end else if (sel1_pc) begin
            dec_o.src1_sel = `ID_SRC1_PC;
        end else begin
            dec_o.src1_sel = `ID_SRC1_ZERO;
        end

        if (sel2_reg2) begin
            dec_o.src2_sel = `ID_SRC2_REG2;
        end else if (sel2_imm) begin
            dec_o.src2_sel = `ID_SRC2_IMM;
        end else if (sel2_four) begin
            dec_o.src2_sel = `ID_SRC2_FOUR;
        end else begin
            dec_o.src2_sel = `ID_SRC2_ZERO;
        end

        dec_o.rd  = inst_i[11:7];
        dec_o.rs1 = inst_i[19:15];
        dec_o.rs2 = inst_i[24:20];

        dec_o.rs1_ren = sel1_reg1 | is_jalr | is_branch;
        dec_o.rs2_ren = sel2_reg2 | is_store | is_branch;
        dec_o.reg_wen = is_jalr | is_load | is_op_imm | is_op | is_jal | is_auipc | is_lui;

        dec_o.load_type = ({3{is_load & (funct3 == 3'b000)}} & `ID_LOAD_LB)
                        | ({3{is_load & (funct3 == 3'b100)}} & `ID_LOAD_LBU)
                        | ({3{is_load & (funct3 == 3'b001)}} & `ID_LOAD_LH)
                        | ({3{is_load & (funct3 == 3'b101)}} & `ID_LOAD_LHU)
                        | ({3{is_load & (funct3 == 3'b010)}} & `ID_LOAD_LW);

        dec_o.store_type = ({2{is_store & (funct3 == 3'b000)}} & `ID_STORE_SB)
                         | ({2{is_store & (funct3 == 3'b001)}} & `ID_STORE_SH)
                         | ({2{is_store & (funct3 == 3'b010)}} & `ID_STORE_SW);

        // funct3 010 and 011 are reserved for branches
        dec_o.branch_cond = ({3{is_branch & (funct3 == 3'b000)}} & `ID_BR_EQ)
                          | ({3{is_branch & (funct3 == 3'b001)}} & `ID_BR_NE)
                          | ({3{is_branch & (funct3 == 3'b100)}} & `ID_BR_LT)
                          | ({3{is_branch & (funct3 == 3'b101)}} & `ID_BR_GE)
                          | ({3{is_branch & (funct3 == 3'b110)}} & `ID_BR_LTU)
                          | ({3{is_branch & (funct3 == 3'b111)}} & `ID_BR_GEU);

        dec_o.jmp  = is_jal | op_jalr;
        dec_o.jalr = op_jalr;
    end

endmodule

`default_nettype wire

//--- hdl/id_hazard_bypass.sv
`default_nettype none

module id_hazard_bypass (
    input  logic             clock,
    input  logic             reset,
    input  id_pkg::decode_t  dec_i,
    input  id_pkg::word_t    reg1_data_i,
    input  id_pkg::word_t    reg2_data_i,
    input  id_pkg::fwd_src_t es_fwd_i,
    input  id_pkg::fwd_src_t ms_fwd_i,
    input  id_pkg::fwd_src_t ws_fwd_i,
    input  logic             fs_to_ds_valid_i,
    input  logic             es_allowin_i,
    output id_pkg::word_t    reg1_o,
    output id_pkg::word_t    reg2_o,
    output logic             ds_valid_o,
    output logic             ds_ready_go_o,
    output logic             ds_allowin_o,
    output logic             ds_to_ex_valid_o
);

    logic rs1_stall;
    logic rs2_stall;

    // nearest producer wins, writeback is always final
    function automatic id_pkg::word_t pick_operand(
        input  id_pkg::reg_addr_t addr,
        input  logic              ren,
        input  id_pkg::word_t     rf_data,
        input  id_pkg::fwd_src_t  es,
        input  id_pkg::fwd_src_t  ms,
        input  id_pkg::fwd_src_t  ws,
        output logic              stall
    );
        id_pkg::word_t data;
        if (ren && es.enable && (es.dst == addr)) begin
            data  = es.data;
            stall = es.need_stall;
        end else if (ren && ms.enable && (ms.dst == addr)) begin
            data  = ms.data;
            stall = ms.need_stall;
        end else if (ren && ws.enable && (ws.dst == addr)) begin
            data  = ws.data;
            stall = 1'b0;
        end else begin
            data  = rf_data;
            stall = 1'b0;
        end
        return data;
    endfunction

    always_comb begin
        reg1_o = pick_operand(dec_i.rs1, dec_i.rs1_ren, reg1_data_i,
                              es_fwd_i, ms_fwd_i, ws_fwd_i, rs1_stall);
        reg2_o = pick_operand(dec_i.rs2, dec_i.rs2_ren, reg2_data_i,
                              es_fwd_i, ms_fwd_i, ws_fwd_i, rs2_stall);
    end

    // stage handshake
    assign ds_ready_go_o    = ~rs1_stall & ~rs2_stall;
    assign ds_allowin_o     = ~ds_valid_o | (ds_ready_go_o & es_allowin_i);
    assign ds_to_ex_valid_o = ds_valid_o & ds_ready_go_o;

    // single-entry occupancy, instruction word held upstream
    always_ff @(posedge clock) begin
        if (reset) begin
            ds_valid_o <= 1'b0;
        end else if (ds_allowin_o) begin
            ds_valid_o <= fs_to_ds_valid_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/id_branch_unit.sv
`default_nettype none

`include "id_params.svh"

module id_branch_unit (
    input  id_pkg::decode_t dec_i,
    input  id_pkg::word_t   pc_i,
    input  id_pkg::word_t   reg1_i,
    input  id_pkg::word_t   reg2_i,
    output logic            branch_taken_o,
    output id_pkg::word_t   target_o
);

    logic          equal;
    logic          less_signed;
    logic          less_unsigned;
    id_pkg::word_t target_base;

    // one comparator of each kind, the condition picks the result
    assign equal         = (reg1_i == reg2_i);
    assign less_signed   = ($signed(reg1_i) < $signed(reg2_i));
    assign less_unsigned = (reg1_i < reg2_i);

    always_comb begin
        case (dec_i.branch_cond)
            `ID_BR_NONE: branch_taken_o = 1'b0;
            `ID_BR_EQ:   branch_taken_o = equal;
            `ID_BR_NE:   branch_taken_o = ~equal;
            `ID_BR_LT:   branch_taken_o = less_signed;
            `ID_BR_GE:   branch_taken_o = ~less_signed;
            `ID_BR_LTU:  branch_taken_o = less_unsigned;
            `ID_BR_GEU:  branch_taken_o = ~less_unsigned;
            default:     branch_taken_o = 1'b0;
        endcase
    end

    // shared adder for branch, jal and jalr targets
    assign target_base = dec_i.jalr ? reg1_i : pc_i;
    assign target_o    = target_base + dec_i.imm;

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`default_nettype none

module id_stage (
    input  logic             clock,
    input  logic             reset,
    input  id_pkg::word_t    inst_i,
    input  id_pkg::word_t    pc_i,
    input  id_pkg::word_t    reg1_data_i,
    input  id_pkg::word_t    reg2_data_i,
    input  logic             fs_to_ds_valid_i,
    input  logic             es_allowin_i,
    input  id_pkg::fwd_src_t es_fwd_i,
    input  id_pkg::fwd_src_t ms_fwd_i,
    input  id_pkg::fwd_src_t ws_fwd_i,
    output id_pkg::decode_t  dec_o,
    output id_pkg::word_t    reg1_o,
    output id_pkg::word_t    reg2_o,
    output logic             ds_valid_o,
    output logic             ds_ready_go_o,
    output logic             ds_allowin_o,
    output logic             ds_to_ex_valid_o,
    output logic             branch_taken_o,
    output id_pkg::word_t    target_o
);

    id_pkg::decode_t dec;

    assign dec_o = dec;

    id_decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec)
    );

    // operands after forwarding feed both the branch unit and execute
    id_hazard_bypass u_hazard_bypass (
        .clock            (clock),
        .reset            (reset),
        .dec_i            (dec),
        .reg1_data_i      (reg1_data_i),
        .reg2_data_i      (reg2_data_i),
        .es_fwd_i         (es_fwd_i),
        .ms_fwd_i         (ms_fwd_i),
        .ws_fwd_i         (ws_fwd_i),
        .fs_to_ds_valid_i (fs_to_ds_valid_i),
        .es_allowin_i     (es_allowin_i),
        .reg1_o           (reg1_o),
        .reg2_o           (reg2_o),
        .ds_valid_o       (ds_valid_o),
        .ds_ready_go_o    (ds_ready_go_o),
        .ds_allowin_o     (ds_allowin_o),
        .ds_to_ex_valid_o (ds_to_ex_valid_o)
    );

    id_branch_unit u_branch_unit (
        .dec_i          (dec),
        .pc_i           (pc_i),
        .reg1_i         (reg1_o),
        .reg2_i         (reg2_o),
        .branch_taken_o (branch_taken_o),
        .target_o       (target_o)
    );

endmodule

`default_nettype wire

//--- dv/id_stage_sva.sv
`default_nettype none

`include "id_params.svh"

module id_stage_sva (
    input logic             clock,
    input logic             reset,
    input id_pkg::word_t    inst_i, pc_i, reg1_data_i, reg2_data_i,
    input id_pkg::fwd_src_t es_fwd_i, ms_fwd_i, ws_fwd_i,
    input logic             fs_to_ds_valid_i, es_allowin_i,
    input id_pkg::decode_t  dec_o,
    input id_pkg::word_t    reg1_o, reg2_o, target_o,
    input logic             ds_valid_o, ds_ready_go_o, ds_allowin_o, ds_to_ex_valid_o,
    input logic             branch_taken_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    logic [6:0] opc;
    logic [2:0] f3;
    logic       rs1_ren;
    logic       rs2_ren;
    logic       stall_exp;

    assign opc = inst_i[6:0];
    assign f3  = inst_i[14:12];
    assign rs1_ren = opc inside {`ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LOAD, `ID_OPC_STORE,
                                 `ID_OPC_JALR, `ID_OPC_BRANCH};
    assign rs2_ren = opc inside {`ID_OPC_OP, `ID_OPC_STORE, `ID_OPC_BRANCH};

    // RV32I immediate by format
    function automatic id_pkg::word_t exp_imm(id_pkg::word_t w);
        case (w[6:0])
            `ID_OPC_OP_IMM, `ID_OPC_LOAD, `ID_OPC_JALR: return {{20{w[31]}}, w[31:20]};
            `ID_OPC_STORE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            `ID_OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            `ID_OPC_LUI, `ID_OPC_AUIPC: return {w[31:12], 12'h000};
            `ID_OPC_JAL:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:        return '0;
        endcase
    endfunction

    function automatic id_pkg::alu_op_t exp_alu(id_pkg::word_t w);
        if (!(w[6:0] inside {`ID_OPC_OP, `ID_OPC_OP_IMM})) begin
            return (w[6:0] inside {`ID_OPC_LOAD, `ID_OPC_STORE, `ID_OPC_JAL, `ID_OPC_JALR,
                                   `ID_OPC_AUIPC, `ID_OPC_LUI}) ? `ID_ALU_ADD : 4'd0;
        end
        case (w[14:12])
            3'b000:  return (w[6:0] == `ID_OPC_OP && w[30]) ? `ID_ALU_SUB : `ID_ALU_ADD;
            3'b001:  return `ID_ALU_SLL;
            3'b010:  return `ID_ALU_SLT;
            3'b011:  return `ID_ALU_SLTU;
            3'b100:  return `ID_ALU_XOR;
            3'b101:  return w[30] ? `ID_ALU_SRA : `ID_ALU_SRL;
            3'b110:  return `ID_ALU_OR;
            default: return `ID_ALU_AND;
        endcase
    endfunction

    // load width and sign by funct3
    function automatic id_pkg::load_type_t exp_load(id_pkg::word_t w);
        if (w[6:0] != `ID_OPC_LOAD) return 3'd0;
        case (w[14:12])
            3'b000:  return `ID_LOAD_LB;
            3'b001:  return `ID_LOAD_LH;
            3'b010:  return `ID_LOAD_LW;
            3'b100:  return `ID_LOAD_LBU;
            3'b101:  return `ID_LOAD_LHU;
            default: return 3'd0;
        endcase
    endfunction

    function automatic id_pkg::store_type_t exp_store(id_pkg::word_t w);
        if (w[6:0] != `ID_OPC_STORE) return 2'd0;
        case (w[14:12])
            3'b000:  return `ID_STORE_SB;
            3'b001:  return `ID_STORE_SH;
            3'b010:  return `ID_STORE_SW;
            default: return 2'd0;
        endcase
    endfunction

    function automatic id_pkg::branch_cond_t exp_cond(id_pkg::word_t w);
        if (w[6:0] != `ID_OPC_BRANCH) return `ID_BR_NONE;
        case (w[14:12])
            3'b000:  return `ID_BR_EQ;
            3'b001:  return `ID_BR_NE;
            3'b100:  return `ID_BR_LT;
            3'b101:  return `ID_BR_GE;
            3'b110:  return `ID_BR_LTU;
            3'b111:  return `ID_BR_GEU;
            default: return `ID_BR_NONE;
        endcase
    endfunction

    // execute beats memory beats writeback beats the register file
    function automatic id_pkg::word_t fwd_data(id_pkg::reg_addr_t a, logic ren,
                                               id_pkg::word_t rf);
        if (ren && es_fwd_i.enable && es_fwd_i.dst == a) return es_fwd_i.data;
        if (ren && ms_fwd_i.enable && ms_fwd_i.dst == a) return ms_fwd_i.data;
        if (ren && ws_fwd_i.enable && ws_fwd_i.dst == a) return ws_fwd_i.data;
        return rf;
    endfunction

    function automatic logic fwd_stall(id_pkg::reg_addr_t a, logic ren);
        if (ren && es_fwd_i.enable && es_fwd_i.dst == a) return es_fwd_i.need_stall;
        if (ren && ms_fwd_i.enable && ms_fwd_i.dst == a) return ms_fwd_i.need_stall;
        return 1'b0;
    endfunction

    function automatic logic exp_taken(id_pkg::word_t a, id_pkg::word_t b);
        if (opc != `ID_OPC_BRANCH) return 1'b0;
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    id_pkg::word_t op1;
    id_pkg::word_t op2;
    id_pkg::word_t tgt_exp;

    always_comb begin
        op1       = fwd_data(inst_i[19:15], rs1_ren, reg1_data_i);
        op2       = fwd_data(inst_i[24:20], rs2_ren, reg2_data_i);
        stall_exp = fwd_stall(inst_i[19:15], rs1_ren) | fwd_stall(inst_i[24:20], rs2_ren);
    end

    assign tgt_exp = ((opc == `ID_OPC_JALR && f3 == 3'b000) ? op1 : pc_i) + exp_imm(inst_i);

    a_reset: assert property (@(posedge clock)
        $past(reset) |-> !ds_valid_o && !ds_to_ex_valid_o && !branch_taken_o)
        else begin
            $error("FAIL %0t: stage not empty after reset", $time);
            fail_count++;
        end

    a_fields: assert property (@(posedge clock) disable iff (reset)
        dec_o.imm == exp_imm(inst_i) && dec_o.rd == inst_i[11:7]
        && dec_o.rs1 == inst_i[19:15] && dec_o.rs2 == inst_i[24:20])
        else begin
            $error("FAIL %0t: immediate or register fields wrong", $time);
            fail_count++;
        end

    a_ctrl: assert property (@(posedge clock) disable iff (reset)
        dec_o.alu_op == exp_alu(inst_i)
        && dec_o.reg_wen == (opc inside {`ID_OPC_JALR, `ID_OPC_LOAD, `ID_OPC_OP_IMM, `ID_OPC_OP,
                                         `ID_OPC_JAL, `ID_OPC_AUIPC, `ID_OPC_LUI})
        && dec_o.src1_sel == ((opc inside {`ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LOAD,
                                           `ID_OPC_STORE}) ? `ID_SRC1_REG1 :
                              (opc inside {`ID_OPC_JAL, `ID_OPC_JALR, `ID_OPC_AUIPC}) ?
                              `ID_SRC1_PC : `ID_SRC1_ZERO)
        && dec_o.src2_sel == ((opc == `ID_OPC_OP) ? `ID_SRC2_REG2 :
                              (opc inside {`ID_OPC_OP_IMM, `ID_OPC_LUI, `ID_OPC_AUIPC,
                                           `ID_OPC_LOAD, `ID_OPC_STORE}) ? `ID_SRC2_IMM :
                              (opc inside {`ID_OPC_JAL, `ID_OPC_JALR}) ?
                              `ID_SRC2_FOUR : `ID_SRC2_ZERO))
        else begin
            $error("FAIL %0t: decoded control wrong", $time);
            fail_count++;
        end

    a_kind: assert property (@(posedge clock) disable iff (reset)
        dec_o.rs1_ren == rs1_ren && dec_o.rs2_ren == rs2_ren
        && dec_o.load_type == exp_load(inst_i) && dec_o.store_type == exp_store(inst_i)
        && dec_o.branch_cond == exp_cond(inst_i)
        && dec_o.jalr == (opc == `ID_OPC_JALR && f3 == 3'b000)
        && dec_o.jmp == (opc == `ID_OPC_JAL || (opc == `ID_OPC_JALR && f3 == 3'b000)))
        else begin
            $error("FAIL %0t: read enables, access types or jump flags wrong", $time);
            fail_count++;
        end

    a_fwd: assert property (@(posedge clock) disable iff (reset)
        reg1_o == op1 && reg2_o == op2)
        else begin
            $error("FAIL %0t: forwarded operand wrong", $time);
            fail_count++;
        end

    a_stall: assert property (@(posedge clock) disable iff (reset)
        ds_ready_go_o == !stall_exp && ds_to_ex_valid_o == (ds_valid_o && !stall_exp)
        && ds_allowin_o == (!ds_valid_o || (!stall_exp && es_allowin_i)))
        else begin
            $error("FAIL %0t: stall or handshake strobe wrong", $time);
            fail_count++;
        end

    a_valid: assert property (@(posedge clock) disable iff (reset)
        ds_valid_o == ($past(ds_allowin_o) ? $past(fs_to_ds_valid_i) : $past(ds_valid_o)))
        else begin
            $error("FAIL %0t: stage valid register wrong", $time);
            fail_count++;
        end

    a_branch: assert property (@(posedge clock) disable iff (reset)
        branch_taken_o == exp_taken(op1, op2) && target_o == tgt_exp)
        else begin
            $error("FAIL %0t: branch outcome or target wrong", $time);
            fail_count++;
        end

endmodule

bind id_stage id_stage_sva u_sva (.*);

`default_nettype wire

//--- dv/id_stage_tb.sv
`default_nettype none

`include "id_params.svh"

module id_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_DEC = 160;
    localparam int N_FWD = 160;
    localparam int N_BR  = 120;
    localparam int TOTAL_CYCLES = 3 + 30 + N_DEC + N_FWD + N_BR;

    logic             clock;
    logic             reset;
    id_pkg::word_t    inst_i;
    id_pkg::word_t    pc_i;
    id_pkg::word_t    reg1_data_i;
    id_pkg::word_t    reg2_data_i;
    logic             fs_to_ds_valid_i;
    logic             es_allowin_i;
    id_pkg::fwd_src_t es_fwd_i;
    id_pkg::fwd_src_t ms_fwd_i;
    id_pkg::fwd_src_t ws_fwd_i;
    id_pkg::decode_t  dec_o;
    id_pkg::word_t    reg1_o;
    id_pkg::word_t    reg2_o;
    id_pkg::word_t    target_o;
    logic             ds_valid_o;
    logic             ds_ready_go_o;
    logic             ds_allowin_o;
    logic             ds_to_ex_valid_o;
    logic             branch_taken_o;

    int tests_passed = 0;
    int tests_failed = 0;
    int fails_before = 0;
    int wait_failures = 0;

    id_stage UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic finish_test(string name);
        int errors;
        errors = UUT.u_sva.fail_count + wait_failures;
        if (errors == fails_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failures", name, errors - fails_before);
        end
        fails_before = errors;
    endtask

    // random legal word of one class
    // kind 0 op-imm 1 op 2 load 3 store 4 lui 5 auipc 6 jal 7 jalr
    function automatic id_pkg::word_t random_inst(int kind);
        id_pkg::word_t w;
        logic [2:0]    ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        w = $urandom;
        case (kind)
            0: begin
                w[6:0] = `ID_OPC_OP_IMM;
                if (w[13:12] == 2'b01) w[31:25] = w[14] ? {1'b0, w[30], 5'b0} : 7'b0;
            end
            1: begin
                w[6:0] = `ID_OPC_OP;
                w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[30]) ? 7'h20 : 7'h00;
            end
            2: begin
                w[6:0] = `ID_OPC_LOAD;
                w[14:12] = ld_f3[$urandom_range(4)];
            end
            3: begin
                w[6:0] = `ID_OPC_STORE;
                w[14:12] = 3'($urandom_range(2));
            end
            4: w[6:0] = `ID_OPC_LUI;
            5: w[6:0] = `ID_OPC_AUIPC;
            6: w[6:0] = `ID_OPC_JAL;
            default: begin
                w[6:0] = `ID_OPC_JALR;
                w[14:12] = 3'b000;
            end
        endcase
        return w;
    endfunction

    function automatic id_pkg::fwd_src_t random_fwd(id_pkg::reg_addr_t a, id_pkg::reg_addr_t b);
        id_pkg::fwd_src_t f;
        int               pick;
        pick = $urandom_range(2);
        f.enable     = $urandom_range(3) != 0;
        f.dst        = (pick == 0) ? a : (pick == 1) ? b : 5'($urandom);
        f.data       = $urandom;
        f.need_stall = $urandom_range(3) == 0;
        return f;
    endfunction

    task automatic wait_stage_valid(int limit);
        int n;
        n = 0;
        while (!ds_valid_o && n < limit) begin
            next_cycle();
            n++;
        end
        if (!ds_valid_o) begin
            $display("stage valid never rose within %0d cycles", limit);
            wait_failures++;
        end
    endtask

    initial begin
        #((TOTAL_CYCLES + 50) * 100);
        $display("watchdog expired, the run took longer than its tests allow");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h82f72f91));
        reset = 1'b1;
        inst_i = '0;
        pc_i = '0;
        reg1_data_i = '0;
        reg2_data_i = '0;
        fs_to_ds_valid_i = 1'b0;
        es_allowin_i = 1'b1;
        es_fwd_i = '0;
        ms_fwd_i = '0;
        ws_fwd_i = '0;
        repeat (3) @(posedge clock);
        #5;
        reset = 1'b0;

        // empty stage first, then the first valid
        inst_i = {12'd1, 5'd0, 3'b000, 5'd1, `ID_OPC_OP_IMM};
        repeat (2) next_cycle();
        fs_to_ds_valid_i = 1'b1;
        next_cycle();
        wait_stage_valid(10);
        finish_test("reset_and_first_valid");

        // back-pressure from execute
        es_allowin_i = 1'b0;
        repeat (4) next_cycle();
        es_allowin_i = 1'b1;
        repeat (2) next_cycle();
        finish_test("back_pressure");

        for (int i = 0; i < N_DEC; i++) begin
            inst_i = random_inst(i % 8);
            pc_i = {$urandom} & 32'hffff_fffc;
            reg1_data_i = $urandom;
            reg2_data_i = $urandom;
            next_cycle();
        end
        finish_test("decode");

        for (int i = 0; i < N_FWD; i++) begin
            inst_i = random_inst(1);
            reg1_data_i = $urandom;
            reg2_data_i = $urandom;
            es_fwd_i = random_fwd(inst_i[19:15], inst_i[24:20]);
            ms_fwd_i = random_fwd(inst_i[19:15], inst_i[24:20]);
            ws_fwd_i = random_fwd(inst_i[19:15], inst_i[24:20]);
            fs_to_ds_valid_i = $urandom_range(3) != 0;
            es_allowin_i = $urandom_range(3) != 0;
            next_cycle();
        end
        es_fwd_i = '0;
        ms_fwd_i = '0;
        ws_fwd_i = '0;
        es_allowin_i = 1'b1;
        finish_test("forwarding");

        // equal operands reach every branch condition
        for (int i = 0; i < N_BR; i++) begin
            inst_i = $urandom;
            if (i % 4 == 3) begin
                inst_i[6:0] = `ID_OPC_JALR;
                inst_i[14:12] = 3'b000;
            end else begin
                inst_i[6:0] = `ID_OPC_BRANCH;
                inst_i[14:12] = (i % 6 < 2) ? 3'(i % 6) : 3'((i % 6) + 2);
            end
            pc_i = {$urandom} & 32'hffff_fffc;
            reg1_data_i = $urandom;
            reg2_data_i = (i % 5 == 0) ? reg1_data_i : $urandom;
            next_cycle();
        end
        next_cycle();
        finish_test("branch_and_target");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_hazard_bypass.sv
hdl/id_branch_unit.sv
hdl/id_stage.sv
dv/id_stage_sva.sv
dv/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module id_stage_tb \
    -o id_stage_sim > build.log 2>&1 \
    && ./obj_dir/id_stage_sim +verilator+error+limit+100000 > sim.log 2>&1 \
    && ! grep -q "Some tests failed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
